/* rv_control_fsm.sv */
// instruction sequencer: fetch, execute, memory, writeback
// owns the program counter, instruction register and retire record
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_control_fsm import rv_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    run,
    input  logic    timer_done,
    input  decode_t dec,
    input  word_t   fetch_data,
    input  word_t   next_pc,
    input  word_t   rd_data,
    output logic    timer_start,
    output word_t   pc,
    output word_t   inst,
    output logic    mem_phase,
    output logic    wb_en,
    output logic    retire_valid,
    output retire_t retire
);

    core_state_t state, next_state;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:      if (run) next_state = FETCH;
            FETCH:     if (timer_done) next_state = EXECUTE;
            EXECUTE:   next_state = (dec.is_load || dec.is_store) ? MEMORY : WRITEBACK;
            MEMORY:    if (timer_done) next_state = WRITEBACK;
            WRITEBACK: next_state = run ? FETCH : IDLE;
            default:   next_state = IDLE;
        endcase
    end

    // timer loads on the edge into a wait state
    assign timer_start = (next_state != state) && (next_state inside {FETCH, MEMORY});

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (state == IDLE && run) begin
            pc <= `RESET_PC;  // every run starts over
        end else if (state == WRITEBACK) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && timer_done)
            inst <= fetch_data;
    end

    // store commit strobe, last cycle of the memory wait
    assign mem_phase = (state == MEMORY) && timer_done && dec.is_store;

    assign wb_en        = (state == WRITEBACK) && dec.writes_rd && (dec.rd != '0);
    assign retire_valid = (state == WRITEBACK);

    always_comb begin
        retire.pc      = pc;
        retire.next_pc = next_pc;
        retire.rd      = dec.rd;
        retire.rd_we   = wb_en;
        retire.rd_data = rd_data;
    end

endmodule

/* rv_core_sva.sv */
// retire sequencing checks for the multicycle core
// pulse width, minimum spacing and pc continuity
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_core_sva import rv_pkg::*; (
    input logic    clk,
    input logic    reset,
    input logic    retire_valid,
    input retire_t retire
);

    localparam int QUIET = `MEM_LATENCY + 1;  // low cycles between two retires

    word_t last_next_pc;
    logic  seen;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            seen         <= 1'b0;
            last_next_pc <= '0;
        end else if (retire_valid) begin
            seen         <= 1'b1;
            last_next_pc <= retire.next_pc;
        end
    end

    a_pulse: assert property (@(posedge clk) disable iff (reset)
        retire_valid |=> !retire_valid)
        else $error("retire_valid high for more than one cycle");

    a_spacing: assert property (@(posedge clk) disable iff (reset)
        retire_valid |=> !retire_valid [*QUIET])
        else $error("two retires closer than MEM_LATENCY+2 cycles");

    a_pc_chain: assert property (@(posedge clk) disable iff (reset)
        retire_valid && seen |-> retire.pc == last_next_pc)
        else $error("retire pc %h does not follow next_pc %h", retire.pc, last_next_pc);

    // first instruction after reset
    a_first_pc: assert property (@(posedge clk) disable iff (reset)
        retire_valid && !seen |-> retire.pc == `RESET_PC)
        else $error("first retire pc %h is not the reset pc", retire.pc);

endmodule

/* rv_core_top.sv */
// multicycle rv32i core top level
// control FSM, latency timer, memories, decode, register file and execute
`timescale 1ns/10ps

module rv_core_top import rv_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       run,
    input  logic       imem_we,
    input  imem_addr_t imem_waddr,
    input  word_t      imem_wdata,
    output logic       retire_valid,
    output retire_t    retire
);

    logic    timer_start, timer_done;
    logic    mem_phase, wb_en;
    word_t   pc, inst, fetch_data;
    word_t   next_pc, rd_data;
    word_t   rs1_data, rs2_data;
    word_t   mem_addr, store_data, load_data;
    decode_t dec;

    rv_control_fsm u_fsm (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .timer_done  (timer_done),
        .dec         (dec),
        .fetch_data  (fetch_data),
        .next_pc     (next_pc),
        .rd_data     (rd_data),
        .timer_start (timer_start),
        .pc          (pc),
        .inst        (inst),
        .mem_phase   (mem_phase),
        .wb_en       (wb_en),
        .retire_valid(retire_valid),
        .retire      (retire)
    );

    rv_wait_timer u_timer (
        .clk  (clk),
        .reset(reset),
        .start(timer_start),
        .done (timer_done)
    );

    rv_imem u_imem (
        .clk  (clk),
        .we   (imem_we),
        .waddr(imem_waddr),
        .wdata(imem_wdata),
        .pc   (pc),
        .rdata(fetch_data)
    );

    rv_decoder u_decoder (
        .inst(inst),
        .dec (dec)
    );

    rv_regfile u_regfile (
        .clk   (clk),
        .reset (reset),
        .we    (wb_en),
        .waddr (dec.rd),
        .raddr1(dec.rs1),
        .raddr2(dec.rs2),
        .wdata (rd_data),
        .rdata1(rs1_data),
        .rdata2(rs2_data)
    );

    rv_execute u_execute (
        .dec       (dec),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .load_data (load_data),
        .mem_addr  (mem_addr),
        .store_data(store_data),
        .next_pc   (next_pc),
        .rd_data   (rd_data)
    );

    rv_dmem u_dmem (
        .clk     (clk),
        .store_en(mem_phase),
        .addr    (mem_addr),
        .wdata   (store_data),
        .rdata   (load_data)
    );

endmodule

/* rv_decoder.sv */
// instruction decode: fields, format class, immediate, alu operation
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_decoder import rv_pkg::*; (
    input  word_t   inst,
    output decode_t dec
);

    logic [6:0] funct7;

    assign funct7 = inst[31:25];

    always_comb begin
        dec.opcode = inst[6:0];
        dec.funct3 = inst[14:12];
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];

        case (inst[6:0])
            `OP_ALUR:                     dec.inst_type = TYPE_R;
            `OP_ALUI, `OP_LOAD, `OP_JALR: dec.inst_type = TYPE_I;
            `OP_STORE:                    dec.inst_type = TYPE_S;
            `OP_BRANCH:                   dec.inst_type = TYPE_B;
            `OP_LUI, `OP_AUIPC:           dec.inst_type = TYPE_U;
            `OP_JAL:                      dec.inst_type = TYPE_J;
            default:                      dec.inst_type = TYPE_N;
        endcase

        // sign extension per format
        case (dec.inst_type)
            TYPE_I:  dec.imm = {{20{inst[31]}}, inst[31:20]};
            TYPE_S:  dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            TYPE_B:  dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            TYPE_U:  dec.imm = {inst[31:12], 12'b0};
            TYPE_J:  dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: dec.imm = '0;
        endcase

        dec.alu_op = ALU_ADD;  // address and target adds
        if (inst[6:0] == `OP_ALUI || inst[6:0] == `OP_ALUR) begin
            case (inst[14:12])
                3'b000: begin
                    if (inst[6:0] == `OP_ALUR && funct7[5])
                        dec.alu_op = ALU_SUB;
                end
                3'b001:  dec.alu_op = ALU_SLL;
                3'b010:  dec.alu_op = ALU_SLT;
                3'b011:  dec.alu_op = ALU_SLTU;
                3'b100:  dec.alu_op = ALU_XOR;
                3'b101:  dec.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110:  dec.alu_op = ALU_OR;
                default: dec.alu_op = ALU_AND;
            endcase
        end

        dec.is_load   = (inst[6:0] == `OP_LOAD);
        dec.is_store  = (inst[6:0] == `OP_STORE);
        dec.writes_rd = dec.inst_type inside {TYPE_R, TYPE_I, TYPE_U, TYPE_J};
    end

endmodule

/* rv_defines.svh */
// shared constants for the multicycle rv32i core
// widths, opcode values, memory sizes and access latency
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

`define XLEN        32
`define RESET_PC    32'h0000_0000

`define IMEM_DEPTH  256
`define DMEM_DEPTH  256

// wait cycles for every fetch and load/store, must be at least 1
`define MEM_LATENCY 3

// base opcodes, inst[6:0]
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_BRANCH   7'b1100011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_ALUI     7'b0010011
`define OP_ALUR     7'b0110011

`endif

/* rv_dmem.sv */
// word data memory for lw and sw
// registered read so load data holds through writeback
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_dmem import rv_pkg::*; (
    input  logic  clk,
    input  logic  store_en,
    input  word_t addr,
    input  word_t wdata,
    output word_t rdata
);

    localparam int AW = $clog2(`DMEM_DEPTH);

    word_t          mem [`DMEM_DEPTH];
    logic  [AW-1:0] idx;

    // byte offset and bits above the array are dropped
    assign idx = addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (store_en)
            mem[idx] <= wdata;
    end

    always_ff @(posedge clk) begin
        rdata <= mem[idx];
    end

endmodule

/* rv_execute.sv */
// alu, branch compare, next pc and writeback data select
// also supplies the data memory address and store word
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_execute import rv_pkg::*; (
    input  decode_t dec,
    input  word_t   pc,
    input  word_t   rs1_data,
    input  word_t   rs2_data,
    input  word_t   load_data,
    output word_t   mem_addr,
    output word_t   store_data,
    output word_t   next_pc,
    output word_t   rd_data
);

    word_t alu_a, alu_b, alu_result, pc_plus4;
    logic  taken, is_link;

    always_comb begin
        case (dec.inst_type)
            TYPE_I, TYPE_S: begin
                alu_a = rs1_data;
                alu_b = dec.imm;
            end
            TYPE_U: begin
                alu_a = (dec.opcode == `OP_LUI) ? '0 : pc;
                alu_b = dec.imm;
            end
            TYPE_B, TYPE_J: begin  // target add
                alu_a = pc;
                alu_b = dec.imm;
            end
            default: begin
                alu_a = rs1_data;
                alu_b = rs2_data;
            end
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            ALU_SUB:  alu_result = alu_a - alu_b;
            ALU_SLL:  alu_result = alu_a << alu_b[4:0];
            ALU_SLT:  alu_result = {{(`XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            ALU_SLTU: alu_result = {{(`XLEN-1){1'b0}}, alu_a < alu_b};
            ALU_XOR:  alu_result = alu_a ^ alu_b;
            ALU_SRL:  alu_result = alu_a >> alu_b[4:0];
            ALU_SRA:  alu_result = word_t'($signed(alu_a) >>> alu_b[4:0]);
            ALU_OR:   alu_result = alu_a | alu_b;
            ALU_AND:  alu_result = alu_a & alu_b;
            default:  alu_result = alu_a + alu_b;
        endcase
    end

    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rs1_data == rs2_data);
            3'b001:  taken = (rs1_data != rs2_data);
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  taken = (rs1_data < rs2_data);
            3'b111:  taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + 32'd4;
    assign is_link  = (dec.opcode == `OP_JAL) || (dec.opcode == `OP_JALR);

    always_comb begin
        if (dec.opcode == `OP_JALR)
            next_pc = {alu_result[`XLEN-1:1], 1'b0};
        else if (dec.inst_type == TYPE_J || (dec.inst_type == TYPE_B && taken))
            next_pc = alu_result;
        else
            next_pc = pc_plus4;
    end

    assign rd_data    = dec.is_load ? load_data : (is_link ? pc_plus4 : alu_result);
    assign mem_addr   = alu_result;
    assign store_data = rs2_data;

endmodule

/* rv_imem.sv */
// instruction memory, loaded through the write port
// asynchronous word read addressed by pc
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_imem import rv_pkg::*; (
    input  logic       clk,
    input  logic       we,
    input  imem_addr_t waddr,
    input  word_t      wdata,
    input  word_t      pc,
    output word_t      rdata
);

    localparam int AW = $bits(imem_addr_t);

    word_t      mem [`IMEM_DEPTH];
    imem_addr_t rd_idx;

    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    assign rd_idx = pc[AW+1:2];  // word index, upper bits wrap
    assign rdata  = mem[rd_idx];

endmodule

/* rv_pkg.sv */
// types shared by the core modules
// data words, register indices, decode and retire records
package rv_pkg;

`include "rv_defines.svh"

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [$clog2(`IMEM_DEPTH)-1:0] imem_addr_t;

    // instruction format classes
    typedef enum logic [2:0] {
        TYPE_R,
        TYPE_I,
        TYPE_S,
        TYPE_B,
        TYPE_U,
        TYPE_J,
        TYPE_N  // no operands / unsupported
    } inst_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } core_state_t;

    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        reg_addr_t  rd;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        word_t      imm;
        inst_t      inst_type;
        alu_op_t    alu_op;
        logic       is_load;
        logic       is_store;
        logic       writes_rd;
    } decode_t;

    // one record per completed instruction
    typedef struct packed {
        word_t     pc;
        word_t     next_pc;
        reg_addr_t rd;
        logic      rd_we;
        word_t     rd_data;
    } retire_t;

endpackage

/* rv_regfile.sv */
// general purpose registers x0..x31, x0 reads as zero
`timescale 1ns/10ps

module rv_regfile import rv_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      we,
    input  reg_addr_t waddr,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  word_t     wdata,
    output word_t     rdata1,
    output word_t     rdata2
);

    word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

/* rv_wait_timer.sv */
// fixed memory latency model, counts down from MEM_LATENCY
`timescale 1ns/10ps
`include "rv_defines.svh"

module rv_wait_timer (
    input  logic clk,
    input  logic reset,
    input  logic start,
    output logic done
);

    localparam int CW = $clog2(`MEM_LATENCY + 1);

    logic [CW-1:0] count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= CW'(`MEM_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    // final wait cycle, count reaches zero on this edge
    assign done = (count == CW'(1));

endmodule

/* tb_rv_core.sv */
// testbench for the multicycle rv32i core
// random programs checked against a shadow register file and data memory
`timescale 1ns/10ps
`include "rv_defines.svh"

module tb_rv_core import rv_pkg::*; ();

    logic       clk, reset, run, imem_we;
    imem_addr_t imem_waddr;
    word_t      imem_wdata;
    logic       retire_valid;
    retire_t    retire;

    logic [31:0] lfsr;
    word_t       prog [`IMEM_DEPTH];
    word_t       sreg [32];
    word_t       sdm [`DMEM_DEPTH];
    word_t       gen_pc;
    retire_t     exp_q [$];
    int          tid_q [$];
    int          checks [5];
    int          fails [5];
    string       names [5] = '{"reset_idle", "alu", "lui_auipc", "branch_jump", "load_store"};

    rv_core_top UUT (.*);

    bind rv_core_top rv_core_sva u_sva (.*);

    always #4 clk = ~clk;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] take_bits(int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    // also covers R format with imm = {funct7, rs2}
    function automatic word_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                    reg_addr_t rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t alu_rule(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // place one instruction and queue its expected retire record
    task automatic add_inst(input word_t inst, input int tid, input reg_addr_t rd,
                            input logic we, input word_t data, input word_t npc);
        retire_t e;
        e.pc           = gen_pc;
        e.next_pc      = npc;
        e.rd           = rd;
        e.rd_we        = we && (rd != 5'd0);
        e.rd_data      = data;
        prog[gen_pc >> 2] = inst;
        exp_q.push_back(e);
        tid_q.push_back(tid);
        if (e.rd_we)
            sreg[rd] = data;
        gen_pc = npc;
    endtask

    task automatic build_program();
        logic [2:0]  f3;
        logic        alt, imm_form;
        logic [11:0] imm;
        reg_addr_t   rd, rs1, rs2;
        word_t       b;
        gen_pc = `RESET_PC;
        foreach (sreg[i])
            sreg[i] = '0;
        for (int i = 0; i < `IMEM_DEPTH; i++)
            prog[i] = enc_i(12'(i), 5'd0, 3'b000, 5'd0, `OP_ALUI);  // x0 write, tagged by address
        for (int k = 0; k < 8; k++) begin  // seeds x1..x8
            rd = reg_addr_t'(k + 1);
            b  = take_bits(20) << 12;
            if (k % 2 == 1)
                add_inst({b[31:12], rd, `OP_AUIPC}, 2, rd, 1'b1, gen_pc + b, gen_pc + 4);
            else
                add_inst({b[31:12], rd, `OP_LUI}, 2, rd, 1'b1, b, gen_pc + 4);
        end
        for (int k = 0; k < 48; k++) begin  // op pattern follows the low bits of k
            f3       = 3'(k);
            imm_form = k[3];
            alt      = k[4] && (f3 == 3'b101 || (f3 == 3'b000 && !imm_form));
            rd       = (k % 7 == 6) ? 5'd0 : reg_addr_t'(take_bits(5));
            rs1      = reg_addr_t'(take_bits(5));
            rs2      = reg_addr_t'(take_bits(5));
            imm      = 12'(take_bits(12));
            if (imm_form && (f3 == 3'b001 || f3 == 3'b101))
                imm = {1'b0, alt, 5'b0, imm[4:0]};
            if (imm_form)
                add_inst(enc_i(imm, rs1, f3, rd, `OP_ALUI), 1, rd, 1'b1,
                         alu_rule(f3, alt, sreg[rs1], {{20{imm[11]}}, imm}), gen_pc + 4);
            else
                add_inst(enc_i({1'b0, alt, 5'b0, rs2}, rs1, f3, rd, `OP_ALUR), 1, rd, 1'b1,
                         alu_rule(f3, alt, sreg[rs1], sreg[rs2]), gen_pc + 4);
        end
        for (int k = 0; k < 16; k++) begin  // offset 8, a taken branch skips one slot
            f3 = 3'(k);
            if (f3 == 3'b010 || f3 == 3'b011)
                continue;
            rs1 = reg_addr_t'(take_bits(5));
            rs2 = (k < 8) ? rs1 : reg_addr_t'(take_bits(5));
            if (k >= 8) begin  // opposite outcome to the equal operand pass
                for (int t = 0; t < 32 && sreg[rs1] == sreg[rs2]; t++)
                    rs2 = reg_addr_t'(take_bits(5));
                if (branch_taken(f3, sreg[rs1], sreg[rs2]) == branch_taken(f3, '0, '0)) begin
                    rd  = rs1;
                    rs1 = rs2;
                    rs2 = rd;
                end
            end
            add_inst({7'b0, rs2, rs1, f3, 5'b01000, `OP_BRANCH}, 3, 5'd0, 1'b0, '0,
                     branch_taken(f3, sreg[rs1], sreg[rs2]) ? gen_pc + 8 : gen_pc + 4);
        end
        for (int k = 0; k < 4; k++) begin
            rd = reg_addr_t'(k + 9);
            if (k % 2 == 1)  // odd target, low bit must be cleared
                add_inst(enc_i(12'(gen_pc + 9), 5'd0, 3'b000, rd, `OP_JALR), 3, rd, 1'b1,
                         gen_pc + 4, gen_pc + 8);
            else
                add_inst({1'b0, 10'd4, 1'b0, 8'd0, rd, `OP_JAL}, 3, rd, 1'b1,
                         gen_pc + 4, gen_pc + 8);
        end
        for (int k = 0; k < 6; k++) begin
            imm = 12'(take_bits(8)) << 2;
            rs2 = reg_addr_t'(take_bits(5));
            rd  = reg_addr_t'(k + 12);
            add_inst({imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], `OP_STORE}, 4, 5'd0, 1'b0, '0,
                     gen_pc + 4);
            sdm[imm[9:2]] = sreg[rs2];
            add_inst(enc_i(imm, 5'd0, 3'b010, rd, `OP_LOAD), 4, rd, 1'b1, sdm[imm[9:2]],
                     gen_pc + 4);
        end
    endtask

    task automatic check_word(input int tid, input string field, input word_t exp,
                              input word_t act);
        checks[tid]++;
        assert (act == exp) else begin
            fails[tid]++;
            $display("FAILED %s %s expected %h actual %h", names[tid], field, exp, act);
        end
    endtask

    task automatic report_test(input int tid);
        $display("test %-12s %0d checks, %0d failed", names[tid], checks[tid], fails[tid]);
    endtask

    initial begin
        retire_t e;
        int      tid, waited, errors, total;
        logic    first;
        clk        = 1'b0;
        reset      = 1'b1;
        run        = 1'b0;
        imem_we    = 1'b0;
        imem_waddr = '0;
        imem_wdata = '0;
        lfsr       = 32'd72591;
        first      = 1'b1;
        foreach (checks[i]) begin
            checks[i] = 0;
            fails[i]  = 0;
        end
        build_program();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < `IMEM_DEPTH; i++) begin  // core idle while loading
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_waddr <= imem_addr_t'(i);
            imem_wdata <= prog[i];
            @(negedge clk);
            check_word(0, "retire_valid", 32'd0, retire_valid);
        end
        @(posedge clk);
        imem_we <= 1'b0;
        run     <= 1'b1;
        while (exp_q.size() > 0) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
            end while (!retire_valid && waited < 50);
            if (!retire_valid) begin
                $display("no retire within 50 cycles, %0d instructions outstanding",
                         exp_q.size());
                fails[tid_q[0]]++;
                break;
            end
            if (first) begin
                check_word(0, "first pc", `RESET_PC, retire.pc);
                report_test(0);
                first = 1'b0;
            end
            e   = exp_q.pop_front();
            tid = tid_q.pop_front();
            check_word(tid, "pc", e.pc, retire.pc);
            check_word(tid, "next_pc", e.next_pc, retire.next_pc);
            check_word(tid, "rd_we", e.rd_we, retire.rd_we);
            if (e.rd_we) begin
                check_word(tid, "rd", e.rd, retire.rd);
                check_word(tid, "rd_data", e.rd_data, retire.rd_data);
            end
            if (tid_q.size() == 0 || tid_q[0] != tid)
                report_test(tid);
        end
        errors = 0;
        total  = 0;
        foreach (fails[i]) begin
            errors += fails[i];
            total  += checks[i];
        end
        $display("%0d checks, %0d failed", total, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+.
rv_pkg.sv
rv_wait_timer.sv
rv_imem.sv
rv_dmem.sv
rv_decoder.sv
rv_regfile.sv
rv_execute.sv
rv_control_fsm.sv
rv_core_top.sv
rv_core_sva.sv
tb_rv_core.sv
